// File: all.f
src/cpu16_pkg.sv
src/sram_port.sv
src/core_ctrl.sv
src/inst_decode.sv
src/execute_unit.sv
src/writeback_unit.sv
src/cpu16_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_top -f all.f

sim:
	verilator --binary --timing --top-module tb_top -f all.f -o tb_sim
	@out=$$(./obj_dir/tb_sim); echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

// File: verif/tb_top.sv
module tb_top;
	import cpu16_pkg::*;

	logic clk;
	logic rst;
	word_t ram_addr;
	word_t ram_wdata;
	logic ram_drive;
	logic ram_en;
	logic ram_oe;
	logic ram_we;
	word_t ram_rdata;
	logic retire;
	word_t retire_pc;
	logic retire_wen;
	reg_idx_t retire_reg;
	word_t retire_value;
	int retires;
	int errors;
	int tests_run;
	int tests_failed;
	word_t mem [65536];

	always #4 clk = ~clk;

	// Asynchronous SRAM, read through, write on rising WE
	assign ram_rdata = (!ram_en && !ram_oe) ? mem[ram_addr] : 16'h0000;

	always @(posedge ram_we) begin
		if (ram_drive && !ram_en) mem[ram_addr] = ram_wdata;
	end

	cpu16_top cpu16_top_i (
		.clk(clk),
		.rst(rst),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_drive(ram_drive),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.ram_rdata(ram_rdata),
		.retire(retire),
		.retire_pc(retire_pc),
		.retire_wen(retire_wen),
		.retire_reg(retire_reg),
		.retire_value(retire_value)
	);

	tb_checker checker_i (
		.clk(clk),
		.rst(rst),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_drive(ram_drive),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.retire(retire),
		.retire_pc(retire_pc),
		.retire_wen(retire_wen),
		.retire_reg(retire_reg),
		.retire_value(retire_value),
		.retires(retires),
		.errors(errors)
	);

	function automatic word_t make_i(input logic [4:0] op, input reg_idx_t rx,
		input logic [7:0] imm);
		instr_u w;
		w.i.op = op;
		w.i.rx = rx;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic word_t make_r(input logic [4:0] op, input reg_idx_t rx,
		input reg_idx_t ry, input reg_idx_t rz, input logic [1:0] fn);
		instr_u w;
		w.r.op = op;
		w.r.rx = rx;
		w.r.ry = ry;
		w.r.rz = rz;
		w.r.fn = fn;
		return w;
	endfunction

	task automatic put_word(input word_t addr, input word_t val);
		mem[addr] = val;
		checker_i.set_word(addr, val);
	endtask

	task automatic fill_background();
		for (int a = 0; a < 65536; a++) begin
			put_word(word_t'(a), {a[7:0], a[15:8]} ^ 16'hc3a5);
		end
	endtask

	////////////////////////////////////////
	// Test sequencing
	////////////////////////////////////////

	task automatic begin_reset(input bit tag_on);
		@(posedge clk);
		#1 rst = 1'b0;
		@(negedge clk);
		checker_i.begin_test(tag_on);
	endtask

	task automatic release_reset();
		repeat (3) @(posedge clk);
		#1 rst = 1'b1;
	endtask

	task automatic wait_retires(input int n, output bit ok);
		int start;
		int cycles;
		start = retires;
		cycles = 0;
		ok = 1'b1;
		while (retires - start < n) begin
			@(posedge clk);
			cycles++;
			if (cycles > n * 100) begin
				$display("core stopped retiring after %0d of %0d instructions",
					retires - start, n);
				ok = 1'b0;
				break;
			end
		end
	endtask

	task automatic end_test(input string name, input bit ok, input int err0);
		tests_run++;
		if (!ok || errors != err0) begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - err0);
		end else begin
			$display("%s: passed", name);
		end
	endtask

	initial begin
		int err0;
		bit ok;
		logic [31:0] r;
		word_t p;
		clk = 1'b0;
		rst = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(32'hb729));

		err0 = errors;
		begin_reset(1'b0);
		fill_background();
		release_reset();
		repeat (2) @(posedge clk);
		end_test("reset state", 1'b1, err0);

		// ADDIU, LI and RR only
		err0 = errors;
		begin_reset(1'b0);
		fill_background();
		for (int i = 0; i < 220; i++) begin
			r = $urandom;
			if (r[1:0] == 2'd0) begin
				put_word(word_t'(i), make_i(OP_ADDIU, r[4:2], r[12:5]));
			end else if (r[1:0] == 2'd1) begin
				put_word(word_t'(i), make_i(OP_LI, r[4:2], r[12:5]));
			end else begin
				put_word(word_t'(i), make_r(OP_RR, r[4:2], r[7:5], r[10:8], r[12:11]));
			end
		end
		release_reset();
		wait_retires(200, ok);
		end_test("alu program", ok, err0);

		// Data window at 0x80..0xff, program below it
		err0 = errors;
		begin_reset(1'b0);
		fill_background();
		p = '0;
		for (int i = 0; i < 20; i++) begin
			r = $urandom;
			put_word(p, make_i(OP_LI, 3'd1, {1'b1, r[6:0]}));
			put_word(p + 16'd1, make_i(OP_LI, 3'd2, r[14:7]));
			put_word(p + 16'd2, make_i(OP_ADDIU, 3'd2, r[22:15]));
			put_word(p + 16'd3, make_r(OP_SW, 3'd1, 3'd2, 3'd0, 2'd0));
			put_word(p + 16'd4, make_i(OP_LI, 3'd3, {1'b1, r[29:23]}));
			put_word(p + 16'd5, make_r(OP_LW, 3'd3, {1'b1, r[31:30]}, 3'd0, 2'd0));
			p = p + 16'd6;
		end
		release_reset();
		wait_retires(120, ok);
		end_test("load store", ok, err0);

		err0 = errors;
		begin_reset(1'b0);
		fill_background();
		for (int i = 0; i < 1024; i++) begin
			r = $urandom;
			if (r[0]) begin
				put_word(word_t'(i), make_i(OP_B, r[3:1], r[15:8]));
			end else begin
				put_word(word_t'(i), make_i(OP_ADDIU, r[3:1], r[15:8]));
			end
		end
		release_reset();
		wait_retires(200, ok);
		end_test("branches", ok, err0);

		// SW at 3 overwrites itself with a branch to self
		err0 = errors;
		begin_reset(1'b1);
		fill_background();
		put_word(16'd0, make_i(OP_LI, 3'd1, 8'h03));
		put_word(16'd1, make_i(OP_LI, 3'd3, 8'h80));
		put_word(16'd2, make_r(OP_LW, 3'd3, 3'd2, 3'd0, 2'd0));
		put_word(16'd3, make_r(OP_SW, 3'd1, 3'd2, 3'd0, 2'd0));
		put_word(16'd4, make_i(OP_B, 3'd0, 8'hfe));
		put_word(16'h0080, make_i(OP_B, 3'd0, 8'hff));
		release_reset();
		wait_retires(30, ok);
		end_test("fetch tag", ok, err0);

		err0 = errors;
		begin_reset(1'b0);
		for (int a = 0; a < 65536; a++) begin
			r = $urandom;
			put_word(word_t'(a), r[15:0]);
		end
		release_reset();
		wait_retires(300, ok);
		end_test("random mix", ok, err0);

		$display("%0d tests, %0d passed, %0d failed", tests_run,
			tests_run - tests_failed, tests_failed);
		if (tests_failed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: verif/tb_checker.sv
module tb_checker (
	input clk,
	input rst,
	input cpu16_pkg::word_t ram_addr,
	input cpu16_pkg::word_t ram_wdata,
	input ram_drive,
	input ram_en,
	input ram_oe,
	input ram_we,
	input retire,
	input cpu16_pkg::word_t retire_pc,
	input retire_wen,
	input cpu16_pkg::reg_idx_t retire_reg,
	input cpu16_pkg::word_t retire_value,
	output int retires,
	output int errors
);
	import cpu16_pkg::*;

	word_t model_mem [65536];
	word_t m_regs [8];
	word_t m_pc;
	word_t last_pc;
	word_t wr_addr_q [$];
	word_t wr_data_q [$];
	logic prev_we;
	logic prev_oe;
	logic prev_rst;
	int reads;
	bit tag_mode;

	initial begin
		retires = 0;
		errors = 0;
		prev_we = 1'b1;
		prev_oe = 1'b1;
		prev_rst = 1'b0;
	end

	task automatic set_word(input word_t addr, input word_t val);
		model_mem[addr] = val;
	endtask

	task automatic begin_test(input bit tag_on);
		for (int i = 0; i < 8; i++) begin
			m_regs[i] = '0;
		end
		m_pc = '0;
		last_pc = 16'hffff;
		reads = 0;
		tag_mode = tag_on;
		wr_addr_q.delete();
		wr_data_q.delete();
	endtask

	task automatic report_mismatch(input string sig, input word_t exp, input word_t act);
		$display("FAILED %s expected %h actual %h", sig, exp, act);
		errors++;
	endtask

	task automatic check_idle_bus();
		if (ram_en !== 1'b1) report_mismatch("ram_en", 16'h1, {15'h0, ram_en});
		if (ram_oe !== 1'b1) report_mismatch("ram_oe", 16'h1, {15'h0, ram_oe});
		if (ram_we !== 1'b1) report_mismatch("ram_we", 16'h1, {15'h0, ram_we});
		if (ram_drive !== 1'b0) report_mismatch("ram_drive", 16'h0, {15'h0, ram_drive});
		if (retire !== 1'b0) report_mismatch("retire", 16'h0, {15'h0, retire});
	endtask

	// Pair a retired store with the oldest SRAM write seen
	task automatic check_store(input word_t addr, input word_t data);
		word_t got_addr;
		word_t got_data;
		if (wr_addr_q.size() == 0) begin
			$display("store at pc %h retired without any SRAM write", m_pc);
			errors++;
		end else begin
			got_addr = wr_addr_q.pop_front();
			got_data = wr_data_q.pop_front();
			if (got_addr !== addr) report_mismatch("ram_addr", addr, got_addr);
			if (got_data !== data) report_mismatch("ram_wdata", data, got_data);
		end
	endtask

	////////////////////////////////////////
	// Instruction-set model
	////////////////////////////////////////

	task automatic step_model();
		instr_u w;
		word_t sext;
		word_t nxt;
		word_t val;
		logic wen;
		reg_idx_t dst;
		w = model_mem[m_pc];
		sext = {{8{w.i.imm[7]}}, w.i.imm};
		nxt = m_pc + 16'd1;
		wen = 1'b0;
		dst = w.i.rx;
		val = '0;
		retires++;
		if (retire_pc !== m_pc) report_mismatch("retire_pc", m_pc, retire_pc);
		case (w.r.op)
			OP_ADDIU: begin
				wen = 1'b1;
				val = m_regs[w.i.rx] + sext;
			end
			OP_LI: begin
				wen = 1'b1;
				val = {8'h00, w.i.imm};
			end
			OP_RR: begin
				wen = 1'b1;
				dst = w.r.rz;
				case (w.r.fn)
					FN_ADDU: val = m_regs[w.r.rx] + m_regs[w.r.ry];
					FN_SUBU: val = m_regs[w.r.rx] - m_regs[w.r.ry];
					FN_AND: val = m_regs[w.r.rx] & m_regs[w.r.ry];
					default: val = m_regs[w.r.rx] | m_regs[w.r.ry];
				endcase
			end
			OP_LW: begin
				wen = 1'b1;
				dst = w.r.ry;
				val = model_mem[m_regs[w.r.rx]];
			end
			OP_SW: begin
				check_store(m_regs[w.r.rx], m_regs[w.r.ry]);
				model_mem[m_regs[w.r.rx]] = m_regs[w.r.ry];
			end
			OP_B: nxt = m_pc + 16'd1 + sext;
			default: ;
		endcase
		// Only a store may leave an SRAM write behind
		if (w.r.op != OP_SW && wr_addr_q.size() != 0) begin
			$display("SRAM write to %h happened with no store retiring", wr_addr_q[0]);
			errors++;
			wr_addr_q.delete();
			wr_data_q.delete();
		end
		if (retire_wen !== wen) report_mismatch("retire_wen", {15'h0, wen}, {15'h0, retire_wen});
		if (wen) begin
			if (retire_reg !== dst) report_mismatch("retire_reg", {13'h0, dst}, {13'h0, retire_reg});
			if (retire_value !== val) report_mismatch("retire_value", val, retire_value);
			m_regs[dst] = val;
		end
		// Repeated fetch must hit the tag, any other fetch must read
		if (tag_mode) begin
			if (m_pc == last_pc && reads != 0) begin
				$display("repeated fetch at %h still read the SRAM", m_pc);
				errors++;
			end else if (m_pc != last_pc && reads == 0) begin
				$display("fetch of new address %h made no SRAM read", m_pc);
				errors++;
			end
		end
		last_pc = m_pc;
		reads = 0;
		m_pc = nxt;
	endtask

	// Sample at the falling edge where all DUT outputs are settled
	always @(negedge clk) begin
		if (!rst || !prev_rst) begin
			check_idle_bus();
		end
		if (rst) begin
			if (prev_oe && !ram_oe) reads++;
			if (!prev_we && ram_we && ram_drive) begin
				wr_addr_q.push_back(ram_addr);
				wr_data_q.push_back(ram_wdata);
			end
			if (retire) step_model();
		end
		prev_we = ram_we;
		prev_oe = ram_oe;
		prev_rst = rst;
	end

endmodule

// File: src/cpu16_top.sv
module cpu16_top (
	input clk,
	input rst,
	output cpu16_pkg::word_t ram_addr,
	output cpu16_pkg::word_t ram_wdata,
	output logic ram_drive,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,
	input cpu16_pkg::word_t ram_rdata,
	output logic retire,
	output cpu16_pkg::word_t retire_pc,
	output logic retire_wen,
	output cpu16_pkg::reg_idx_t retire_reg,
	output cpu16_pkg::word_t retire_value
);
	import cpu16_pkg::*;

	logic fetch_req;
	logic fetch_done;
	word_t fetch_addr;
	word_t fetch_data;
	logic data_req;
	logic data_we;
	logic data_done;
	word_t data_addr;
	word_t data_wdata;
	word_t data_rdata;
	instr_u ir;
	word_t pc;
	word_t next_pc;
	logic wb_step;
	op_class_e op_class;
	reg_idx_t rs_a;
	reg_idx_t rs_b;
	reg_idx_t rd;
	logic [1:0] fn;
	logic [7:0] imm;
	word_t a;
	word_t b;
	word_t result;

	////////////////////////////////////////
	// Memory port
	////////////////////////////////////////

	sram_port sram_port_i (
		.clk(clk),
		.rst(rst),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.fetch_done(fetch_done),
		.fetch_data(fetch_data),
		.data_req(data_req),
		.data_we(data_we),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_done(data_done),
		.data_rdata(data_rdata),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_drive(ram_drive),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.ram_rdata(ram_rdata)
	);

	////////////////////////////////////////
	// Core
	////////////////////////////////////////

	core_ctrl core_ctrl_i (
		.clk(clk),
		.rst(rst),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.fetch_done(fetch_done),
		.fetch_data(fetch_data),
		.data_req(data_req),
		.data_we(data_we),
		.data_done(data_done),
		.ir(ir),
		.pc(pc),
		.op_class(op_class),
		.next_pc(next_pc),
		.wb_step(wb_step)
	);

	inst_decode inst_decode_i (
		.ir(ir),
		.op_class(op_class),
		.rs_a(rs_a),
		.rs_b(rs_b),
		.rd(rd),
		.fn(fn),
		.imm(imm)
	);

	execute_unit execute_unit_i (
		.op_class(op_class),
		.fn(fn),
		.imm(imm),
		.a(a),
		.b(b),
		.pc(pc),
		.result(result),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.next_pc(next_pc)
	);

	writeback_unit writeback_unit_i (
		.clk(clk),
		.rst(rst),
		.wb_step(wb_step),
		.op_class(op_class),
		.rs_a(rs_a),
		.rs_b(rs_b),
		.rd(rd),
		.alu_result(result),
		.load_data(data_rdata),
		.pc(pc),
		.a(a),
		.b(b),
		.retire(retire),
		.retire_pc(retire_pc),
		.retire_wen(retire_wen),
		.retire_reg(retire_reg),
		.retire_value(retire_value)
	);

endmodule

// File: src/writeback_unit.sv
module writeback_unit (
	input clk,
	input rst,
	input wb_step,
	input cpu16_pkg::op_class_e op_class,
	input cpu16_pkg::reg_idx_t rs_a,
	input cpu16_pkg::reg_idx_t rs_b,
	input cpu16_pkg::reg_idx_t rd,
	input cpu16_pkg::word_t alu_result,
	input cpu16_pkg::word_t load_data,
	input cpu16_pkg::word_t pc,
	output cpu16_pkg::word_t a,
	output cpu16_pkg::word_t b,
	output logic retire,
	output cpu16_pkg::word_t retire_pc,
	output logic retire_wen,
	output cpu16_pkg::reg_idx_t retire_reg,
	output cpu16_pkg::word_t retire_value
);
	import cpu16_pkg::*;

	word_t regs [8];
	logic writes;
	word_t wr_value;

	assign a = regs[rs_a];
	assign b = regs[rs_b];

	assign writes = (op_class == ALU_RR) || (op_class == ALU_IMM) ||
		(op_class == LOAD_IMM) || (op_class == LOAD);
	assign wr_value = (op_class == LOAD) ? load_data : alu_result;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
			retire <= 1'b0;
			retire_wen <= 1'b0;
		end else begin
			retire <= wb_step;
			if (wb_step) begin
				retire_wen <= writes;
				if (writes) begin
					regs[rd] <= wr_value;
				end
			end
		end
	end

	// Retire report, pc is still the retiring one here
	always_ff @(posedge clk) begin
		if (wb_step) begin
			retire_pc <= pc;
			retire_reg <= rd;
			retire_value <= wr_value;
		end
	end

endmodule

// File: src/execute_unit.sv
module execute_unit (
	input cpu16_pkg::op_class_e op_class,
	input [1:0] fn,
	input [7:0] imm,
	input cpu16_pkg::word_t a,
	input cpu16_pkg::word_t b,
	input cpu16_pkg::word_t pc,
	output cpu16_pkg::word_t result,
	output cpu16_pkg::word_t data_addr,
	output cpu16_pkg::word_t data_wdata,
	output cpu16_pkg::word_t next_pc
);
	import cpu16_pkg::*;

	word_t imm_sext;
	word_t imm_zext;
	word_t rr_result;

	assign imm_sext = {{8{imm[7]}}, imm};
	assign imm_zext = {8'h00, imm};

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////

	always_comb begin
		case (fn)
			FN_ADDU: rr_result = a + b;
			FN_SUBU: rr_result = a - b;
			FN_AND: rr_result = a & b;
			FN_OR: rr_result = a | b;
			default: rr_result = a + b;
		endcase
	end

	always_comb begin
		case (op_class)
			ALU_RR: result = rr_result;
			ALU_IMM: result = a + imm_sext;
			LOAD_IMM: result = imm_zext;
			default: result = a;
		endcase
	end

	// Loads and stores address through rx, store data from ry
	assign data_addr = a;
	assign data_wdata = b;

	// Branch offset is relative to the following word
	always_comb begin
		if (op_class == BRANCH) begin
			next_pc = pc + 16'd1 + imm_sext;
		end else begin
			next_pc = pc + 16'd1;
		end
	end

endmodule

// File: src/inst_decode.sv
module inst_decode (
	input cpu16_pkg::instr_u ir,
	output cpu16_pkg::op_class_e op_class,
	output cpu16_pkg::reg_idx_t rs_a,
	output cpu16_pkg::reg_idx_t rs_b,
	output cpu16_pkg::reg_idx_t rd,
	output logic [1:0] fn,
	output logic [7:0] imm
);
	import cpu16_pkg::*;

	// Register fields come from the R view
	assign rs_a = ir.r.rx;
	assign rs_b = ir.r.ry;
	assign fn = ir.r.fn;

	// Immediate from the I view
	assign imm = ir.i.imm;

	always_comb begin
		case (ir.r.op)
			OP_ADDIU: op_class = ALU_IMM;
			OP_LI: op_class = LOAD_IMM;
			OP_RR: op_class = ALU_RR;
			OP_LW: op_class = LOAD;
			OP_SW: op_class = STORE;
			OP_B: op_class = BRANCH;
			default: op_class = NOP;
		endcase
	end

	// Destination depends on the format
	always_comb begin
		case (op_class)
			ALU_RR: rd = ir.r.rz;
			LOAD: rd = ir.r.ry;
			default: rd = ir.i.rx;
		endcase
	end

endmodule

// File: src/core_ctrl.sv
module core_ctrl (
	input clk,
	input rst,
	output logic fetch_req,
	output cpu16_pkg::word_t fetch_addr,
	input fetch_done,
	input cpu16_pkg::word_t fetch_data,
	output logic data_req,
	output logic data_we,
	input data_done,
	output cpu16_pkg::instr_u ir,
	output cpu16_pkg::word_t pc,
	input cpu16_pkg::op_class_e op_class,
	input cpu16_pkg::word_t next_pc,
	output logic wb_step
);
	import cpu16_pkg::*;

	logic [2:0] state;

	assign fetch_req = (state == CS_FETCH);
	assign fetch_addr = pc;
	assign data_req = (state == CS_MEM);
	assign data_we = (op_class == STORE);
	assign wb_step = (state == CS_WB);

	////////////////////////////////////////
	// Instruction sequencer
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= CS_FETCH;
			pc <= '0;
		end else begin
			case (state)
				CS_FETCH: begin
					if (fetch_done) begin
						state <= CS_DECODE;
					end
				end
				CS_DECODE: begin
					state <= CS_EXEC;
				end
				CS_EXEC: begin
					// Only loads and stores touch memory
					if (op_class == LOAD || op_class == STORE) begin
						state <= CS_MEM;
					end else begin
						state <= CS_WB;
					end
				end
				CS_MEM: begin
					if (data_done) begin
						state <= CS_WB;
					end
				end
				CS_WB: begin
					pc <= next_pc;
					state <= CS_FETCH;
				end
				default: begin
					state <= CS_FETCH;
				end
			endcase
		end
	end

	// Instruction register
	always_ff @(posedge clk) begin
		if (state == CS_FETCH && fetch_done) begin
			ir <= fetch_data;
		end
	end

endmodule

// File: src/sram_port.sv
module sram_port (
	input clk,
	input rst,
	input fetch_req,
	input cpu16_pkg::word_t fetch_addr,
	output logic fetch_done,
	output cpu16_pkg::word_t fetch_data,
	input data_req,
	input data_we,
	input cpu16_pkg::word_t data_addr,
	input cpu16_pkg::word_t data_wdata,
	output logic data_done,
	output cpu16_pkg::word_t data_rdata,
	output cpu16_pkg::word_t ram_addr,
	output cpu16_pkg::word_t ram_wdata,
	output logic ram_drive,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,
	input cpu16_pkg::word_t ram_rdata
);
	import cpu16_pkg::*;

	logic [RAM_DIV_BITS-1:0] cnt;
	logic tick;
	logic [2:0] phase;
	logic serve_data;
	logic tag_valid;
	word_t tag;
	logic tag_hit;

	// Phase machine steps only on counter wrap
	assign tick = (cnt == {RAM_DIV_BITS{1'b1}});
	assign tag_hit = tag_valid && (fetch_addr == tag);

	// Data side owns the bus while it requests
	assign ram_addr = data_req ? data_addr : fetch_addr;
	assign ram_wdata = data_wdata;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt <= '0;
			phase <= SP_IDLE;
			serve_data <= 1'b0;
			tag_valid <= 1'b0;
			ram_en <= 1'b1;
			ram_oe <= 1'b1;
			ram_we <= 1'b1;
			ram_drive <= 1'b0;
			fetch_done <= 1'b0;
			data_done <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
			fetch_done <= 1'b0;
			data_done <= 1'b0;
			if (tick) begin
				case (phase)
					SP_IDLE: begin
						if (data_req) begin
							serve_data <= 1'b1;
							ram_en <= 1'b0;
							if (data_we) begin
								ram_drive <= 1'b1;
								phase <= SP_WR_DRIVE;
								// Stale instruction word after this store
								if (tag_valid && data_addr == tag) begin
									tag_valid <= 1'b0;
								end
							end else begin
								phase <= SP_RD_SETUP;
							end
						end else if (fetch_req) begin
							if (tag_hit) begin
								fetch_done <= 1'b1;
							end else begin
								serve_data <= 1'b0;
								ram_en <= 1'b0;
								phase <= SP_RD_SETUP;
							end
						end
					end
					SP_RD_SETUP: begin
						ram_oe <= 1'b0;
						phase <= SP_RD_OE;
					end
					SP_RD_OE: begin
						phase <= SP_RD_CAP;
					end
					SP_RD_CAP: begin
						ram_oe <= 1'b1;
						ram_en <= 1'b1;
						phase <= SP_IDLE;
						if (serve_data) begin
							data_done <= 1'b1;
						end else begin
							fetch_done <= 1'b1;
							tag_valid <= 1'b1;
						end
					end
					SP_WR_DRIVE: begin
						ram_we <= 1'b0;
						phase <= SP_WR_WE_LOW;
					end
					SP_WR_WE_LOW: begin
						// Rising WE commits the word
						ram_we <= 1'b1;
						phase <= SP_WR_WE_HIGH;
					end
					SP_WR_WE_HIGH: begin
						ram_drive <= 1'b0;
						ram_en <= 1'b1;
						data_done <= 1'b1;
						phase <= SP_IDLE;
					end
					default: begin
						phase <= SP_IDLE;
					end
				endcase
			end
		end
	end

	// Read capture, fetch_data doubles as the tagged word
	always_ff @(posedge clk) begin
		if (tick && phase == SP_RD_CAP) begin
			if (serve_data) begin
				data_rdata <= ram_rdata;
			end else begin
				fetch_data <= ram_rdata;
				tag <= fetch_addr;
			end
		end
	end

endmodule

// File: src/cpu16_pkg.sv
package cpu16_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_idx_t;

	////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////

	localparam logic [4:0] OP_ADDIU = 5'b01001;
	localparam logic [4:0] OP_LI = 5'b01101;
	localparam logic [4:0] OP_RR = 5'b11100;
	localparam logic [4:0] OP_LW = 5'b10011;
	localparam logic [4:0] OP_SW = 5'b11011;
	localparam logic [4:0] OP_B = 5'b00010;

	// RR function field
	localparam logic [1:0] FN_ADDU = 2'b00;
	localparam logic [1:0] FN_SUBU = 2'b01;
	localparam logic [1:0] FN_AND = 2'b10;
	localparam logic [1:0] FN_OR = 2'b11;

	typedef struct packed {
		logic [4:0] op;
		reg_idx_t rx;
		reg_idx_t ry;
		reg_idx_t rz;
		logic [1:0] fn;
	} instr_r_t;

	typedef struct packed {
		logic [4:0] op;
		reg_idx_t rx;
		logic [7:0] imm;
	} instr_i_t;

	// Same word, read as R or I format
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_RR,
		ALU_IMM,
		LOAD_IMM,
		LOAD,
		STORE,
		BRANCH,
		NOP
	} op_class_e;

	////////////////////////////////////////
	// Memory port and sequencer
	////////////////////////////////////////

	// One SRAM phase is 2^RAM_DIV_BITS clocks
	localparam int RAM_DIV_BITS = 2;

	localparam logic [2:0] SP_IDLE = 3'd0;
	localparam logic [2:0] SP_RD_SETUP = 3'd1;
	localparam logic [2:0] SP_RD_OE = 3'd2;
	localparam logic [2:0] SP_RD_CAP = 3'd3;
	localparam logic [2:0] SP_WR_DRIVE = 3'd4;
	localparam logic [2:0] SP_WR_WE_LOW = 3'd5;
	localparam logic [2:0] SP_WR_WE_HIGH = 3'd6;

	localparam logic [2:0] CS_FETCH = 3'd0;
	localparam logic [2:0] CS_DECODE = 3'd1;
	localparam logic [2:0] CS_EXEC = 3'd2;
	localparam logic [2:0] CS_MEM = 3'd3;
	localparam logic [2:0] CS_WB = 3'd4;

endpackage
